/* src/bk_sound_pkg.sv */
// Sound path shared definitions

package bk_sound_pkg;

    // ========================================================================
    // Widths and timing
    // ========================================================================

    // Output sample word
    localparam int sample_width = 16;

    // CPU bus data word
    localparam int bus_width = 16;

    // System clocks per output sample pair
    localparam int tick_div = 56;

    // ========================================================================
    // Mix field positions
    // ========================================================================

    // Covox byte lands on sample bits 14..7
    localparam int covox_shift = 7;

    // Speaker field lands on sample bits 13..11
    localparam int spk_shift = 11;

    // Tape input adds a single weight at this bit
    localparam int tape_bit = 14;

    // System register data bits feeding speaker bits 2, 1, 0
    localparam int spk_bit2_src = 6;
    localparam int spk_bit1_src = 5;
    localparam int spk_bit0_src = 2;

    // Set on a high-byte write, this bit blocks the speaker update
    localparam int sys_hi_lock_bit = 11;

    // Target of one captured bus write
    typedef enum logic [1:0] {
        wr_none   = 2'd0,
        wr_sysreg = 2'd1,
        wr_port   = 2'd2
    } write_target_t;

endpackage

/* src/bus_write_capture.sv */
// Bus write event capture

module bus_write_capture
    import bk_sound_pkg::*;
(
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  logic                 bus_stb,
    input  logic                 bus_we,
    input  logic                 sysreg_sel,
    input  logic                 port_sel,
    input  logic [1:0]           bus_wtbt,
    input  logic [bus_width-1:0] bus_din,
    output write_target_t        wr_target,
    output logic [bus_width-1:0] wr_data,
    output logic [1:0]           wr_lanes
);

    logic          write_cond;
    logic          write_cond_q;
    logic          write_edge;
    write_target_t target_next;

    // Write in progress to one of the two sound-related selects
    assign write_cond = bus_stb & bus_we & (sysreg_sel | port_sel);

    // Only the first cycle of a held strobe counts
    assign write_edge = write_cond & ~write_cond_q;

    // System register takes priority when both selects are up
    always_comb begin
        if (sysreg_sel) begin
            target_next = wr_sysreg;
        end else begin
            target_next = wr_port;
        end
    end

    // ========================================================================
    // Event register, one cycle per write
    // ========================================================================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            write_cond_q <= 1'b0;
            wr_target    <= wr_none;
        end else begin
            write_cond_q <= write_cond;
            if (write_edge) begin
                wr_target <= target_next;
            end else begin
                wr_target <= wr_none;
            end
        end
    end

    // Data and lanes frozen at the strobe edge
    always_ff @(posedge clk_sys) begin
        if (write_edge) begin
            wr_data  <= bus_din;
            wr_lanes <= bus_wtbt;
        end
    end

endmodule

/* src/sound_regs.sv */
// Speaker and Covox registers

module sound_regs
    import bk_sound_pkg::*;
(
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  write_target_t        wr_target,
    input  logic [bus_width-1:0] wr_data,
    input  logic [1:0]           wr_lanes,
    input  logic                 bk0010,
    output logic [2:0]           spk_bits,
    output logic [bus_width-1:0] covox_data
);

    logic       spk_load;
    logic [2:0] spk_next;
    logic       lo_lane;
    logic       hi_lane;

    assign lo_lane = wr_lanes[0];
    assign hi_lane = wr_lanes[1];

    // ========================================================================
    // System register speaker field
    // ========================================================================

    // Low lane required; a high-byte write with the lock bit set is dropped
    assign spk_load = lo_lane & (~hi_lane | ~wr_data[sys_hi_lock_bit]);

    // Bit 0 does not exist on the BK0010 model
    always_comb begin
        spk_next[2] = wr_data[spk_bit2_src];
        spk_next[1] = wr_data[spk_bit1_src];
        spk_next[0] = wr_data[spk_bit0_src] & ~bk0010;
    end

    // ========================================================================
    // Register update
    // ========================================================================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            spk_bits   <= '0;
            covox_data <= '0;
        end else begin
            case (wr_target)
                wr_sysreg: begin
                    if (spk_load) begin
                        spk_bits <= spk_next;
                    end
                end
                wr_port: begin
                    // Each byte lane updates only its own half
                    if (lo_lane) begin
                        covox_data[7:0] <= wr_data[7:0];
                    end
                    if (hi_lane) begin
                        covox_data[15:8] <= wr_data[15:8];
                    end
                end
                default: begin
                    spk_bits   <= spk_bits;
                    covox_data <= covox_data;
                end
            endcase
        end
    end

endmodule

/* src/sample_mixer.sv */
// Covox sample mixer

module sample_mixer
    import bk_sound_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic [2:0]              spk_bits,
    input  logic [bus_width-1:0]    covox_data,
    input  logic                    tape_in,
    input  logic                    tape_mute,
    output logic [sample_width-1:0] sample_l,
    output logic [sample_width-1:0] sample_r,
    output logic                    sample_valid
);

    logic [$clog2(tick_div)-1:0] tick_cnt;
    logic                        tick;

    logic [sample_width-1:0] covox_l_term;
    logic [sample_width-1:0] covox_r_term;
    logic [sample_width-1:0] spk_term;
    logic [sample_width-1:0] tape_term;
    logic [sample_width-1:0] mix_l;
    logic [sample_width-1:0] mix_r;

    // ========================================================================
    // Sample rate divider
    // ========================================================================

    assign tick = (tick_cnt == $bits(tick_cnt)'(tick_div - 1));

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // ========================================================================
    // Mix terms
    // ========================================================================

    always_comb begin
        covox_l_term = sample_width'(covox_data[7:0]) << covox_shift;
        covox_r_term = sample_width'(covox_data[15:8]) << covox_shift;
        spk_term     = sample_width'(spk_bits) << spk_shift;

        // Tape is heard only when not muted
        if (tape_in && !tape_mute) begin
            tape_term = sample_width'(1) << tape_bit;
        end else begin
            tape_term = '0;
        end

        // Sums wrap at the sample width, no clipping
        mix_l = covox_l_term + spk_term + tape_term;
        mix_r = covox_r_term + spk_term + tape_term;
    end

    // Output samples, refreshed once per tick
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sample_l     <= '0;
            sample_r     <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= tick;
            if (tick) begin
                sample_l <= mix_l;
                sample_r <= mix_r;
            end
        end
    end

endmodule

/* src/bk_sound_top.sv */
// BK0011M sound output path

module bk_sound_top
    import bk_sound_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic                    bus_stb,
    input  logic                    bus_we,
    input  logic                    sysreg_sel,
    input  logic                    port_sel,
    input  logic [1:0]              bus_wtbt,
    input  logic [bus_width-1:0]    bus_din,
    input  logic                    bk0010,
    input  logic                    tape_in,
    input  logic                    tape_mute,
    output logic [sample_width-1:0] sample_l,
    output logic [sample_width-1:0] sample_r,
    output logic                    sample_valid
);

    // ========================================================================
    // Stage links
    // ========================================================================

    write_target_t        wr_target;
    logic [bus_width-1:0] wr_data;
    logic [1:0]           wr_lanes;
    logic [2:0]           spk_bits;
    logic [bus_width-1:0] covox_data;

    bus_write_capture bus_write_capture_inst (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .bus_stb    (bus_stb),
        .bus_we     (bus_we),
        .sysreg_sel (sysreg_sel),
        .port_sel   (port_sel),
        .bus_wtbt   (bus_wtbt),
        .bus_din    (bus_din),
        .wr_target  (wr_target),
        .wr_data    (wr_data),
        .wr_lanes   (wr_lanes)
    );

    sound_regs sound_regs_inst (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .wr_target  (wr_target),
        .wr_data    (wr_data),
        .wr_lanes   (wr_lanes),
        .bk0010     (bk0010),
        .spk_bits   (spk_bits),
        .covox_data (covox_data)
    );

    // Samples follow register levels, sampled on the tick
    sample_mixer sample_mixer_inst (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .spk_bits     (spk_bits),
        .covox_data   (covox_data),
        .tape_in      (tape_in),
        .tape_mute    (tape_mute),
        .sample_l     (sample_l),
        .sample_r     (sample_r),
        .sample_valid (sample_valid)
    );

endmodule

/* verification/tb_bk_sound.sv */
// Sound path testbench

module tb_bk_sound
    import bk_sound_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period        = 8;
    localparam int reset_cycles      = 16;
    localparam int cycles_per_vector = 200;
    localparam int max_gap           = 10;
    localparam string test_file      = "verification/sound_tests.txt";

    logic                    clk_sys;
    logic                    rst_n;
    logic                    bus_stb;
    logic                    bus_we;
    logic                    sysreg_sel;
    logic                    port_sel;
    logic [1:0]              bus_wtbt;
    logic [bus_width-1:0]    bus_din;
    logic                    bk0010;
    logic                    tape_in;
    logic                    tape_mute;
    logic [sample_width-1:0] sample_l;
    logic [sample_width-1:0] sample_r;
    logic                    sample_valid;

    // Vector table, one entry per data line
    logic [1:0]              vec_target[$];
    logic                    vec_we[$];
    logic [1:0]              vec_lanes[$];
    logic [bus_width-1:0]    vec_data[$];
    logic                    vec_bk[$];
    logic                    vec_tape[$];
    logic                    vec_mute[$];
    int                      vec_hold[$];
    logic [sample_width-1:0] vec_exp_l[$];
    logic [sample_width-1:0] vec_exp_r[$];

    int          error_count    = 0;
    bit          vectors_loaded = 1'b0;
    int          since_valid    = 0;
    bit          seen_valid     = 1'b0;

    bk_sound_top bk_sound_top_inst (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .bus_stb      (bus_stb),
        .bus_we       (bus_we),
        .sysreg_sel   (sysreg_sel),
        .port_sel     (port_sel),
        .bus_wtbt     (bus_wtbt),
        .bus_din      (bus_din),
        .bk0010       (bk0010),
        .tape_in      (tape_in),
        .tape_mute    (tape_mute),
        .sample_l     (sample_l),
        .sample_r     (sample_r),
        .sample_valid (sample_valid)
    );

    always #(clk_period / 2) clk_sys = ~clk_sys;

    // ========================================================================
    // Failure reporting
    // ========================================================================

    task automatic fail_and_stop();
        $display("Verification failed");
        $fatal(1, "Stopping on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        fail_and_stop();
    endtask

    // ========================================================================
    // Vector file and bus driving
    // ========================================================================

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [15:0] f_target;
        logic [15:0] f_we;
        logic [15:0] f_lanes;
        logic [15:0] f_data;
        logic [15:0] f_bk;
        logic [15:0] f_tape;
        logic [15:0] f_mute;
        logic [15:0] f_hold;
        logic [15:0] f_exp_l;
        logic [15:0] f_exp_r;
        fd = $fopen(test_file, "r");
        if (fd == 0) begin
            $display("Could not open the test vector file %s", test_file);
            fail_and_stop();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Skip blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_target, f_we, f_lanes,
                        f_data, f_bk, f_tape, f_mute, f_hold, f_exp_l, f_exp_r);
            if (n != 10) begin
                $display("Malformed line in the test vector file: %s", line);
                fail_and_stop();
            end
            vec_target.push_back(f_target[1:0]);
            vec_we.push_back(f_we[0]);
            vec_lanes.push_back(f_lanes[1:0]);
            vec_data.push_back(f_data);
            vec_bk.push_back(f_bk[0]);
            vec_tape.push_back(f_tape[0]);
            vec_mute.push_back(f_mute[0]);
            vec_hold.push_back(int'(f_hold));
            vec_exp_l.push_back(f_exp_l);
            vec_exp_r.push_back(f_exp_r);
        end
        $fclose(fd);
        if (vec_target.size() == 0) begin
            $display("The test vector file holds no vectors");
            fail_and_stop();
        end
    endtask

    task automatic drive_idle();
        bus_stb    = 1'b0;
        bus_we     = 1'b0;
        sysreg_sel = 1'b0;
        port_sel   = 1'b0;
        bus_wtbt   = 2'b00;
        bus_din    = '0;
    endtask

    // Code 3 raises both selects, other codes follow the write target
    task automatic drive_selects(input logic [1:0] code);
        write_target_t target;
        if (code == 2'd3) begin
            sysreg_sel = 1'b1;
            port_sel   = 1'b1;
        end else begin
            target     = write_target_t'(code);
            sysreg_sel = (target == wr_sysreg);
            port_sel   = (target == wr_port);
        end
    endtask

    task automatic apply_vector(input int idx);
        int cyc;
        @(posedge clk_sys);
        #1;
        bk0010    = vec_bk[idx];
        tape_in   = vec_tape[idx];
        tape_mute = vec_mute[idx];
        drive_selects(vec_target[idx]);
        bus_we    = vec_we[idx];
        bus_wtbt  = vec_lanes[idx];
        bus_din   = vec_data[idx];
        bus_stb   = 1'b1;
        for (cyc = 1; cyc < vec_hold[idx]; cyc++) begin
            @(posedge clk_sys);
            #1;
            // Data moves on while the strobe stays high
            bus_din = ~vec_data[idx];
        end
        @(posedge clk_sys);
        #1;
        drive_idle();
    endtask

    task automatic wait_valid();
        do begin
            @(negedge clk_sys);
        end while (sample_valid !== 1'b1);
    endtask

    task automatic check_samples(input int idx);
        assert (sample_l === vec_exp_l[idx]) else begin
            report_mismatch($sformatf("sample_l (vector %0d)", idx),
                            32'(sample_l), 32'(vec_exp_l[idx]));
        end
        assert (sample_r === vec_exp_r[idx]) else begin
            report_mismatch($sformatf("sample_r (vector %0d)", idx),
                            32'(sample_r), 32'(vec_exp_r[idx]));
        end
    endtask

    // ========================================================================
    // Sample tick spacing
    // ========================================================================

    always @(negedge clk_sys) begin
        if (!rst_n) begin
            since_valid = 0;
            seen_valid  = 1'b0;
        end else begin
            since_valid = since_valid + 1;
            if (sample_valid) begin
                if (seen_valid) begin
                    assert (since_valid == tick_div) else begin
                        report_mismatch("sample_valid spacing", since_valid, tick_div);
                    end
                end else begin
                    // First count includes the low phase of the release cycle
                    assert (since_valid - 1 == tick_div) else begin
                        report_mismatch("first sample_valid delay", since_valid - 1,
                                        tick_div);
                    end
                end
                seen_valid  = 1'b1;
                since_valid = 0;
            end
        end
    end

    // Watchdog
    initial begin
        int limit_cycles;
        wait (vectors_loaded);
        limit_cycles = (vec_target.size() + 1) * cycles_per_vector + reset_cycles;
        repeat (limit_cycles) @(posedge clk_sys);
        $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
        fail_and_stop();
    end

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        int idx;
        int gap;
        clk_sys   = 1'b0;
        rst_n     = 1'b0;
        bk0010    = 1'b0;
        tape_in   = 1'b0;
        tape_mute = 1'b0;
        drive_idle();
        void'($urandom(6));
        load_vectors();
        vectors_loaded = 1'b1;

        repeat (reset_cycles) @(posedge clk_sys);
        #1;
        rst_n = 1'b1;

        // Nothing written yet, so the first pair is silent
        wait_valid();
        assert (sample_l === '0) else begin
            report_mismatch("sample_l", 32'(sample_l), 32'h0);
        end
        assert (sample_r === '0) else begin
            report_mismatch("sample_r", 32'(sample_r), 32'h0);
        end

        for (idx = 0; idx < vec_target.size(); idx++) begin
            gap = $urandom_range(max_gap, 0);
            repeat (gap) @(posedge clk_sys);
            apply_vector(idx);
            // Second pulse is sure to carry the new register levels
            wait_valid();
            wait_valid();
            check_samples(idx);
        end

        if (error_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            fail_and_stop();
        end
    end

endmodule

/* verification/sound_tests.txt */
# target: 0 none, 1 sysreg, 2 port, 3 both selects; we; lanes; data; bk0010; tape; mute
# hold (strobe cycles); expected sample_l; expected sample_r. All columns hex.
2 1 1 1234 0 0 0 1 1a00 0000
2 1 2 ab00 0 0 0 1 1a00 5580
2 1 3 0102 0 0 0 1 0100 0080
1 1 1 0064 0 0 0 1 3900 3880
1 1 3 0800 0 0 0 1 3900 3880
1 1 3 0020 0 0 0 1 1100 1080
1 1 2 0064 0 0 0 1 1100 1080
1 1 1 0064 1 0 0 1 3100 3080
1 1 1 0004 1 0 0 1 0100 0080
1 1 1 0004 0 0 0 1 0900 0880
0 1 3 0000 0 1 0 1 4900 4880
0 1 3 0000 0 1 1 1 0900 0880
1 1 1 0064 0 0 0 1 3900 3880
2 1 3 ffff 0 1 0 1 f780 f780
2 1 3 2211 0 0 0 4 4080 4900
2 0 3 0000 0 0 0 2 4080 4900
3 1 3 0004 0 0 0 1 1080 1900
1 1 1 0060 0 0 0 3 3880 4100
2 1 1 00ff 0 1 1 1 af80 4100
0 1 3 0000 0 1 0 1 ef80 8100

/* flist.f */
src/bk_sound_pkg.sv
src/bus_write_capture.sv
src/sound_regs.sv
src/sample_mixer.sv
src/bk_sound_top.sv
verification/tb_bk_sound.sv

/* Makefile */
# Verilator build and run for the sound output path

VERILATOR  ?= verilator
TOP        ?= tb_bk_sound
RTL_TOP    ?= bk_sound_top
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall
FAIL_MSG   ?= Verification failed
PASS_MSG   ?= Verification passed

RTL_SRCS := $(shell grep '^src/' $(FLIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
